/* verilog/lcc_trans_pkg.sv */
// --------------------------------------
// Lifecycle translator shared types
// Lifecycle, class, token and security-state encodings
// --------------------------------------
package lcc_trans_pkg;

  // Default width of the unlock level and of the SoC masks
  parameter int UnlockLevelWidthDefault = 64;

  // Multi-bit enable token from the lifecycle controller
  typedef logic [3:0] lc_tx_t;

  // Only this exact pattern enables, anything else reads as off
  parameter lc_tx_t LcTxOn = 4'b0101;

  // ----------------------------------------
  // Lifecycle states
  // ----------------------------------------
  // Codes above SCRAP are unused and classify as invalid
  typedef enum logic [4:0] {
    RAW            = 5'd0,
    TEST_LOCKED0   = 5'd1,
    TEST_LOCKED1   = 5'd2,
    TEST_LOCKED2   = 5'd3,
    TEST_LOCKED3   = 5'd4,
    TEST_LOCKED4   = 5'd5,
    TEST_LOCKED5   = 5'd6,
    TEST_LOCKED6   = 5'd7,
    TEST_UNLOCKED0 = 5'd8,
    TEST_UNLOCKED1 = 5'd9,
    TEST_UNLOCKED2 = 5'd10,
    TEST_UNLOCKED3 = 5'd11,
    TEST_UNLOCKED4 = 5'd12,
    TEST_UNLOCKED5 = 5'd13,
    TEST_UNLOCKED6 = 5'd14,
    TEST_UNLOCKED7 = 5'd15,
    DEV            = 5'd16,
    PROD           = 5'd17,
    PROD_END       = 5'd18,
    RMA            = 5'd19,
    SCRAP          = 5'd20
  } lc_state_e;

  // Coarse class of the static state, one per translator branch
  typedef enum logic [2:0] {
    CLS_LOCKED   = 3'd0,
    CLS_UNLOCKED = 3'd1,
    CLS_DEV      = 3'd2,
    CLS_PROD     = 3'd3,
    CLS_RMA      = 3'd4,
    CLS_SCRAP    = 3'd5,
    CLS_INVALID  = 3'd6
  } lc_class_e;

  // Core device lifecycle reported with the debug-locked bit
  typedef enum logic [1:0] {
    DEV_UNPROVISIONED = 2'b00,
    DEV_MANUFACTURING = 2'b01,
    DEV_PRODUCTION    = 2'b11
  } device_lifecycle_e;

  // Translator FSM states
  typedef enum logic [2:0] {
    TR_RESET           = 3'd0,
    TR_IDLE            = 3'd1,
    TR_NON_DEBUG       = 3'd2,
    TR_UNPROV_DEBUG    = 3'd3,
    TR_MANUF_NON_DEBUG = 3'd4,
    TR_MANUF_DEBUG     = 3'd5,
    TR_PROD_NON_DEBUG  = 3'd6,
    TR_PROD_DEBUG      = 3'd7
  } trans_state_e;

endpackage

/* verilog/lc_state_capture.sv */
// --------------------------------------
// Static lifecycle state capture
// Holds the fuse state, classifies it, flags scrap requests
// --------------------------------------
`timescale 1ns/1ps

module lc_state_capture (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Fuse controller side
  input  logic                     otp_valid_i,
  input  lcc_trans_pkg::lc_state_e otp_state_i,
  // Live request from the lifecycle controller
  input  logic                     lc_prog_req_i,
  input  lcc_trans_pkg::lc_state_e lc_alive_state_i,
  // To the translator FSM
  output lcc_trans_pkg::lc_class_e static_class_o,
  output logic                     scrap_req_o
);

  lcc_trans_pkg::lc_state_e static_state_q;

  // Static state register
  // Follows the fuse word while valid, falls back to RAW otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      static_state_q <= lcc_trans_pkg::RAW;
    end else if (otp_valid_i) begin
      static_state_q <= otp_state_i;
    end else begin
      static_state_q <= lcc_trans_pkg::RAW;
    end
  end

  // ----------------------------------------
  // Classification of the held state
  // ----------------------------------------
  always_comb begin
    case (static_state_q)
      lcc_trans_pkg::RAW,
      lcc_trans_pkg::TEST_LOCKED0, lcc_trans_pkg::TEST_LOCKED1,
      lcc_trans_pkg::TEST_LOCKED2, lcc_trans_pkg::TEST_LOCKED3,
      lcc_trans_pkg::TEST_LOCKED4, lcc_trans_pkg::TEST_LOCKED5,
      lcc_trans_pkg::TEST_LOCKED6: static_class_o = lcc_trans_pkg::CLS_LOCKED;
      lcc_trans_pkg::TEST_UNLOCKED0, lcc_trans_pkg::TEST_UNLOCKED1,
      lcc_trans_pkg::TEST_UNLOCKED2, lcc_trans_pkg::TEST_UNLOCKED3,
      lcc_trans_pkg::TEST_UNLOCKED4, lcc_trans_pkg::TEST_UNLOCKED5,
      lcc_trans_pkg::TEST_UNLOCKED6,
      lcc_trans_pkg::TEST_UNLOCKED7: static_class_o = lcc_trans_pkg::CLS_UNLOCKED;
      lcc_trans_pkg::DEV:            static_class_o = lcc_trans_pkg::CLS_DEV;
      // PROD_END behaves as PROD for the core
      lcc_trans_pkg::PROD,
      lcc_trans_pkg::PROD_END:       static_class_o = lcc_trans_pkg::CLS_PROD;
      lcc_trans_pkg::RMA:            static_class_o = lcc_trans_pkg::CLS_RMA;
      lcc_trans_pkg::SCRAP:          static_class_o = lcc_trans_pkg::CLS_SCRAP;
      // Unused codes
      default:                       static_class_o = lcc_trans_pkg::CLS_INVALID;
    endcase
  end

  // Scrap request is only valid while the controller sits in SCRAP
  assign scrap_req_o = lc_prog_req_i && (lc_alive_state_i == lcc_trans_pkg::SCRAP);

endmodule

/* verilog/sec_state_fsm.sv */
// --------------------------------------
// Security state translator FSM
// Maps the static class and unlock events to lifecycle and lock
// --------------------------------------
`timescale 1ns/1ps

module sec_state_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             otp_valid_i,
  // From state capture
  input  lcc_trans_pkg::lc_class_e         static_class_i,
  input  logic                             scrap_req_i,
  // SoC and core controls
  input  logic                             state_error_i,
  input  logic                             dbg_manuf_enable_i,
  input  logic                             prod_unlock_i,
  // Registered core security state
  output lcc_trans_pkg::device_lifecycle_e device_lifecycle_o,
  output logic                             debug_locked_o
);

  lcc_trans_pkg::trans_state_e      state_q;
  lcc_trans_pkg::trans_state_e      state_d;
  lcc_trans_pkg::device_lifecycle_e lifecycle_d;
  logic                             locked_d;
  logic                             escape;

  // Scrap or a reported state error forces the sticky non-debug path
  assign escape = scrap_req_i || state_error_i;

  // ----------------------------------------
  // Next state and output decode
  // ----------------------------------------
  always_comb begin
    // Production locked unless a branch says otherwise
    state_d     = state_q;
    lifecycle_d = lcc_trans_pkg::DEV_PRODUCTION;
    locked_d    = 1'b1;
    case (state_q)
      lcc_trans_pkg::TR_RESET: begin
        state_d = lcc_trans_pkg::TR_IDLE;
      end
      lcc_trans_pkg::TR_IDLE: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else begin
          case (static_class_i)
            lcc_trans_pkg::CLS_LOCKED,
            lcc_trans_pkg::CLS_SCRAP:    state_d = lcc_trans_pkg::TR_NON_DEBUG;
            lcc_trans_pkg::CLS_UNLOCKED: state_d = lcc_trans_pkg::TR_UNPROV_DEBUG;
            lcc_trans_pkg::CLS_DEV:      state_d = lcc_trans_pkg::TR_MANUF_NON_DEBUG;
            lcc_trans_pkg::CLS_PROD:     state_d = lcc_trans_pkg::TR_PROD_NON_DEBUG;
            lcc_trans_pkg::CLS_RMA:      state_d = lcc_trans_pkg::TR_PROD_DEBUG;
            // Invalid static state keeps waiting in idle
            default:                     state_d = lcc_trans_pkg::TR_IDLE;
          endcase
        end
      end
      // Sticky until valid drops
      lcc_trans_pkg::TR_NON_DEBUG: begin
        state_d = lcc_trans_pkg::TR_NON_DEBUG;
      end
      lcc_trans_pkg::TR_UNPROV_DEBUG: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else begin
          lifecycle_d = lcc_trans_pkg::DEV_UNPROVISIONED;
          locked_d    = 1'b0;
        end
      end
      lcc_trans_pkg::TR_MANUF_NON_DEBUG: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else begin
          // Still locked on the unlock edge, open one cycle later
          lifecycle_d = lcc_trans_pkg::DEV_MANUFACTURING;
          if (dbg_manuf_enable_i) begin
            state_d = lcc_trans_pkg::TR_MANUF_DEBUG;
          end
        end
      end
      lcc_trans_pkg::TR_MANUF_DEBUG: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else begin
          lifecycle_d = lcc_trans_pkg::DEV_MANUFACTURING;
          locked_d    = 1'b0;
        end
      end
      lcc_trans_pkg::TR_PROD_NON_DEBUG: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else if (prod_unlock_i) begin
          state_d = lcc_trans_pkg::TR_PROD_DEBUG;
        end
      end
      lcc_trans_pkg::TR_PROD_DEBUG: begin
        if (escape) begin
          state_d = lcc_trans_pkg::TR_NON_DEBUG;
        end else begin
          locked_d = 1'b0;
        end
      end
      default: begin
        state_d = lcc_trans_pkg::TR_RESET;
      end
    endcase
  end

  // ----------------------------------------
  // State and output registers
  // ----------------------------------------
  // Advance only on valid edges, otherwise restart from reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= lcc_trans_pkg::TR_RESET;
      device_lifecycle_o <= lcc_trans_pkg::DEV_PRODUCTION;
      debug_locked_o     <= 1'b1;
    end else if (otp_valid_i) begin
      state_q            <= state_d;
      device_lifecycle_o <= lifecycle_d;
      debug_locked_o     <= locked_d;
    end else begin
      state_q            <= lcc_trans_pkg::TR_RESET;
      device_lifecycle_o <= lcc_trans_pkg::DEV_PRODUCTION;
      debug_locked_o     <= 1'b1;
    end
  end

endmodule

/* verilog/debug_en_gen.sv */
// --------------------------------------
// SoC debug enable generation
// Unlock level mask matching and registered DFT and debug enables
// --------------------------------------
`timescale 1ns/1ps

module debug_en_gen #(
  parameter int UnlockWidth = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     otp_valid_i,
  // Enable tokens from the lifecycle controller
  input  lcc_trans_pkg::lc_tx_t    lc_dft_en_i,
  input  lcc_trans_pkg::lc_tx_t    lc_hw_debug_en_i,
  // Unlock level from the core and SoC masks
  input  logic [UnlockWidth-1:0]   unlock_level_i,
  input  logic [UnlockWidth-1:0]   dft_en_mask_i,
  input  logic [UnlockWidth-1:0]   dbg_unlock_mask_i,
  input  logic [UnlockWidth-1:0]   cltap_unlock_mask_i,
  input  logic                     scrap_req_i,
  // Production unlock match to the FSM
  output logic                     prod_unlock_o,
  // Registered SoC enables
  output logic                     soc_dft_en_o,
  output logic                     soc_hw_debug_en_o
);

  logic dft_mask_hit;
  logic hw_dbg_mask_hit;
  logic dft_en_d;
  logic hw_debug_en_d;

  // ----------------------------------------
  // Mask matching
  // ----------------------------------------
  // Any overlapping bit between level and mask counts as a match
  assign dft_mask_hit    = |(unlock_level_i & dft_en_mask_i);
  assign hw_dbg_mask_hit = |(unlock_level_i & cltap_unlock_mask_i);
  assign prod_unlock_o   = |(unlock_level_i & dbg_unlock_mask_i);

  // Token on or mask hit, blocked by a valid scrap request
  assign dft_en_d      = ((lc_dft_en_i == lcc_trans_pkg::LcTxOn) || dft_mask_hit)
                         && !scrap_req_i;
  assign hw_debug_en_d = ((lc_hw_debug_en_i == lcc_trans_pkg::LcTxOn) || hw_dbg_mask_hit)
                         && !scrap_req_i;

  // Enables drop at the first edge without valid fuse data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= dft_en_d;
      soc_hw_debug_en_o <= hw_debug_en_d;
    end else begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

/* verilog/lcc_st_trans.sv */
// --------------------------------------
// Lifecycle state translator top
// Core security state and SoC debug enables from lifecycle inputs
// --------------------------------------
`timescale 1ns/1ps

module lcc_st_trans #(
  parameter int UnlockWidth = lcc_trans_pkg::UnlockLevelWidthDefault
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Fuse controller
  input  logic                             otp_valid_i,
  input  lcc_trans_pkg::lc_state_e         otp_state_i,
  // Lifecycle controller
  input  logic                             lc_prog_req_i,
  input  lcc_trans_pkg::lc_state_e         lc_alive_state_i,
  input  lcc_trans_pkg::lc_tx_t            lc_dft_en_i,
  input  lcc_trans_pkg::lc_tx_t            lc_hw_debug_en_i,
  // SoC error and core manufacturing unlock
  input  logic                             state_error_i,
  input  logic                             dbg_manuf_enable_i,
  // Unlock level and SoC masks
  input  logic [UnlockWidth-1:0]           unlock_level_i,
  input  logic [UnlockWidth-1:0]           dft_en_mask_i,
  input  logic [UnlockWidth-1:0]           dbg_unlock_mask_i,
  input  logic [UnlockWidth-1:0]           cltap_unlock_mask_i,
  // Core security state
  output lcc_trans_pkg::device_lifecycle_e device_lifecycle_o,
  output logic                             debug_locked_o,
  // SoC enables
  output logic                             soc_dft_en_o,
  output logic                             soc_hw_debug_en_o
);

  lcc_trans_pkg::lc_class_e static_class;
  logic                     scrap_req;
  logic                     prod_unlock;

  // Fuse state capture and scrap detection
  lc_state_capture lc_state_capture_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .otp_valid_i      (otp_valid_i),
    .otp_state_i      (otp_state_i),
    .lc_prog_req_i    (lc_prog_req_i),
    .lc_alive_state_i (lc_alive_state_i),
    .static_class_o   (static_class),
    .scrap_req_o      (scrap_req)
  );

  // Translator FSM
  sec_state_fsm sec_state_fsm_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .otp_valid_i        (otp_valid_i),
    .static_class_i     (static_class),
    .scrap_req_i        (scrap_req),
    .state_error_i      (state_error_i),
    .dbg_manuf_enable_i (dbg_manuf_enable_i),
    .prod_unlock_i      (prod_unlock),
    .device_lifecycle_o (device_lifecycle_o),
    .debug_locked_o     (debug_locked_o)
  );

  // Mask matching and SoC enables
  debug_en_gen #(
    .UnlockWidth (UnlockWidth)
  ) debug_en_gen_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .otp_valid_i         (otp_valid_i),
    .lc_dft_en_i         (lc_dft_en_i),
    .lc_hw_debug_en_i    (lc_hw_debug_en_i),
    .unlock_level_i      (unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .scrap_req_i         (scrap_req),
    .prod_unlock_o       (prod_unlock),
    .soc_dft_en_o        (soc_dft_en_o),
    .soc_hw_debug_en_o   (soc_hw_debug_en_o)
  );

endmodule

/* dv/lcc_model.svh */
// --------------------------------------
// Translator reference model for the testbench
// --------------------------------------
`ifndef LCC_MODEL_SVH
`define LCC_MODEL_SVH

// The one enable token value that means on
localparam logic [3:0] TokenOn = 4'b0101;

lcc_trans_pkg::lc_state_e         m_static;
lcc_trans_pkg::trans_state_e      m_state;
lcc_trans_pkg::device_lifecycle_e m_lc;
logic                             m_locked;
logic                             m_dft;
logic                             m_hw;

// Class table by lifecycle code ranges
function automatic lcc_trans_pkg::lc_class_e class_of(logic [4:0] code);
  if (code <= 5'd7) return lcc_trans_pkg::CLS_LOCKED;
  if (code <= 5'd15) return lcc_trans_pkg::CLS_UNLOCKED;
  if (code == 5'd16) return lcc_trans_pkg::CLS_DEV;
  if (code <= 5'd18) return lcc_trans_pkg::CLS_PROD;
  if (code == 5'd19) return lcc_trans_pkg::CLS_RMA;
  if (code == 5'd20) return lcc_trans_pkg::CLS_SCRAP;
  return lcc_trans_pkg::CLS_INVALID;
endfunction

// Values after reset and after any edge without valid
task automatic model_reset();
  m_static = lcc_trans_pkg::RAW;
  m_state  = lcc_trans_pkg::TR_RESET;
  m_lc     = lcc_trans_pkg::DEV_PRODUCTION;
  m_locked = 1'b1;
  m_dft    = 1'b0;
  m_hw     = 1'b0;
endtask

// One rising edge, using the inputs as they stand before the edge
task automatic model_step();
  lcc_trans_pkg::lc_class_e cls;
  logic                     scrap;
  logic                     esc;
  cls   = class_of(m_static);
  scrap = lc_prog_req && (lc_alive_state == lcc_trans_pkg::SCRAP);
  esc   = scrap || state_error;
  if (!otp_valid) begin
    model_reset();
  end else begin
    // Outputs of the current state, escape forces production locked
    m_lc     = lcc_trans_pkg::DEV_PRODUCTION;
    m_locked = 1'b1;
    if (!esc) begin
      case (m_state)
        lcc_trans_pkg::TR_UNPROV_DEBUG: begin
          m_lc     = lcc_trans_pkg::DEV_UNPROVISIONED;
          m_locked = 1'b0;
        end
        lcc_trans_pkg::TR_MANUF_NON_DEBUG: m_lc = lcc_trans_pkg::DEV_MANUFACTURING;
        lcc_trans_pkg::TR_MANUF_DEBUG: begin
          m_lc     = lcc_trans_pkg::DEV_MANUFACTURING;
          m_locked = 1'b0;
        end
        lcc_trans_pkg::TR_PROD_DEBUG: m_locked = 1'b0;
        default: m_locked = 1'b1;
      endcase
    end
    m_dft = ((lc_dft_en == TokenOn) || (|(unlock_level & dft_en_mask))) && !scrap;
    m_hw  = ((lc_hw_debug_en == TokenOn) || (|(unlock_level & cltap_unlock_mask))) && !scrap;
    // Next state
    case (m_state)
      lcc_trans_pkg::TR_RESET: m_state = lcc_trans_pkg::TR_IDLE;
      lcc_trans_pkg::TR_IDLE: begin
        if (esc || cls == lcc_trans_pkg::CLS_LOCKED || cls == lcc_trans_pkg::CLS_SCRAP)
          m_state = lcc_trans_pkg::TR_NON_DEBUG;
        else if (cls == lcc_trans_pkg::CLS_UNLOCKED) m_state = lcc_trans_pkg::TR_UNPROV_DEBUG;
        else if (cls == lcc_trans_pkg::CLS_DEV) m_state = lcc_trans_pkg::TR_MANUF_NON_DEBUG;
        else if (cls == lcc_trans_pkg::CLS_PROD) m_state = lcc_trans_pkg::TR_PROD_NON_DEBUG;
        else if (cls == lcc_trans_pkg::CLS_RMA) m_state = lcc_trans_pkg::TR_PROD_DEBUG;
      end
      default: begin
        if (esc) m_state = lcc_trans_pkg::TR_NON_DEBUG;
        else if (m_state == lcc_trans_pkg::TR_MANUF_NON_DEBUG && dbg_manuf_enable)
          m_state = lcc_trans_pkg::TR_MANUF_DEBUG;
        else if (m_state == lcc_trans_pkg::TR_PROD_NON_DEBUG && (|(unlock_level & dbg_unlock_mask)))
          m_state = lcc_trans_pkg::TR_PROD_DEBUG;
      end
    endcase
    m_static = otp_state;
  end
endtask

`endif

/* dv/tb_lcc_st_trans.sv */
// --------------------------------------
// Lifecycle translator testbench
// Seeded random stimulus against a cycle model
// --------------------------------------
`timescale 1ns/1ps

module tb_lcc_st_trans;

  localparam int Width = lcc_trans_pkg::UnlockLevelWidthDefault;
  // Cycle budget per test for the watchdog
  localparam int ClassIters  = 16;
  localparam int EscapeIters = 10;
  localparam int TotalCycles = 5 + ClassIters * 5 + 8 + 8 + EscapeIters * 8 + 34 + 9;
  localparam int WatchdogNs  = TotalCycles * 10 + 500;

  logic clk_i;
  logic rst_ni;
  logic otp_valid;
  lcc_trans_pkg::lc_state_e otp_state;
  logic lc_prog_req;
  lcc_trans_pkg::lc_state_e lc_alive_state;
  lcc_trans_pkg::lc_tx_t lc_dft_en;
  lcc_trans_pkg::lc_tx_t lc_hw_debug_en;
  logic state_error;
  logic dbg_manuf_enable;
  logic [Width-1:0] unlock_level;
  logic [Width-1:0] dft_en_mask;
  logic [Width-1:0] dbg_unlock_mask;
  logic [Width-1:0] cltap_unlock_mask;
  lcc_trans_pkg::device_lifecycle_e device_lifecycle;
  logic debug_locked;
  logic soc_dft_en;
  logic soc_hw_debug_en;
  int   checks;
  int   errors;

  `include "lcc_model.svh"

  lcc_st_trans #(
    .UnlockWidth (Width)
  ) lcc_st_trans_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .otp_valid_i (otp_valid), .otp_state_i (otp_state),
    .lc_prog_req_i (lc_prog_req), .lc_alive_state_i (lc_alive_state),
    .lc_dft_en_i (lc_dft_en), .lc_hw_debug_en_i (lc_hw_debug_en),
    .state_error_i (state_error), .dbg_manuf_enable_i (dbg_manuf_enable),
    .unlock_level_i (unlock_level), .dft_en_mask_i (dft_en_mask),
    .dbg_unlock_mask_i (dbg_unlock_mask), .cltap_unlock_mask_i (cltap_unlock_mask),
    .device_lifecycle_o (device_lifecycle), .debug_locked_o (debug_locked),
    .soc_dft_en_o (soc_dft_en), .soc_hw_debug_en_o (soc_hw_debug_en)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [Width-1:0] random_wide();
    return Width'({$urandom, $urandom});
  endfunction

  function automatic logic [Width-1:0] one_hot_bit();
    return Width'(1) << $urandom_range(Width - 1);
  endfunction

  task automatic compare_outputs();
    checks++;
    assert (device_lifecycle == m_lc && debug_locked == m_locked &&
            soc_dft_en == m_dft && soc_hw_debug_en == m_hw)
    else begin
      errors++;
      $display("MISMATCH at %0t: got/exp lc %0d/%0d locked %0b/%0b dft %0b/%0b hw %0b/%0b",
               $time, device_lifecycle, m_lc, debug_locked, m_locked,
               soc_dft_en, m_dft, soc_hw_debug_en, m_hw);
    end
  endtask

  // Model steps on the rising edge and the DUT is compared on the falling edge
  task automatic tick();
    @(posedge clk_i);
    model_step();
    @(negedge clk_i);
    compare_outputs();
  endtask

  // Security outputs against one fixed lifecycle and lock value
  task automatic expect_security(lcc_trans_pkg::device_lifecycle_e lc, logic locked);
    checks++;
    assert (device_lifecycle == lc && debug_locked == locked)
    else begin
      errors++;
      $display("MISMATCH at %0t: lc %0d locked %0b, rule says lc %0d locked %0b",
               $time, device_lifecycle, debug_locked, lc, locked);
    end
  endtask

  // One edge without valid, then the three-edge start with a new fuse state
  task automatic restart(logic [4:0] code);
    otp_valid = 1'b0;
    tick();
    otp_state = lcc_trans_pkg::lc_state_e'(code);
    otp_valid = 1'b1;
    repeat (3) tick();
  endtask

  task automatic finish_test(string name, int start_errors);
    $display("test %s finished, %0d errors", name, errors - start_errors);
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin
    #(WatchdogNs);
    $display("ERROR: watchdog expired, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int start;
    void'($urandom(25));
    checks = 0;
    errors = 0;
    rst_ni = 1'b0;
    otp_valid = 1'b0;
    otp_state = lcc_trans_pkg::RAW;
    lc_prog_req = 1'b0;
    lc_alive_state = lcc_trans_pkg::RAW;
    lc_dft_en = 4'h0;
    lc_hw_debug_en = 4'h0;
    state_error = 1'b0;
    dbg_manuf_enable = 1'b0;
    unlock_level = '0;
    dft_en_mask = '0;
    dbg_unlock_mask = '0;
    cltap_unlock_mask = '0;
    model_reset();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    compare_outputs();

    // Class mapping including the invalid codes
    start = errors;
    for (int i = 0; i < ClassIters; i++) begin
      restart(5'($urandom_range(31)));
      tick();
    end
    finish_test("class_mapping", start);

    // Manufacturing unlock opens one edge after the transition
    start = errors;
    restart(5'd16);
    dbg_manuf_enable = 1'b1;
    tick();
    expect_security(lcc_trans_pkg::DEV_MANUFACTURING, 1'b1);
    tick();
    expect_security(lcc_trans_pkg::DEV_MANUFACTURING, 1'b0);
    dbg_manuf_enable = 1'b0;
    repeat (2) tick();
    finish_test("manuf_unlock", start);

    // Production unlock by level and debug mask overlap
    start = errors;
    dbg_unlock_mask = one_hot_bit() | random_wide();
    unlock_level = ~dbg_unlock_mask;
    restart(($urandom_range(1) == 1) ? 5'd17 : 5'd18);
    repeat (2) tick();
    expect_security(lcc_trans_pkg::DEV_PRODUCTION, 1'b1);
    unlock_level = random_wide() & dbg_unlock_mask;
    unlock_level = unlock_level | (dbg_unlock_mask & ~(dbg_unlock_mask - Width'(1)));
    repeat (2) tick();
    expect_security(lcc_trans_pkg::DEV_PRODUCTION, 1'b0);
    unlock_level = '0;
    dbg_unlock_mask = '0;
    finish_test("prod_unlock", start);

    // Escape by scrap or state error stays sticky after the cause clears
    start = errors;
    for (int i = 0; i < EscapeIters; i++) begin
      restart(5'($urandom_range(20)));
      if ($urandom_range(1) == 1) begin
        lc_prog_req = 1'b1;
        lc_alive_state = lcc_trans_pkg::SCRAP;
      end else begin
        state_error = 1'b1;
      end
      tick();
      lc_prog_req = 1'b0;
      state_error = 1'b0;
      dbg_manuf_enable = 1'b1;
      unlock_level = '1;
      dbg_unlock_mask = '1;
      repeat (3) tick();
      expect_security(lcc_trans_pkg::DEV_PRODUCTION, 1'b1);
      dbg_manuf_enable = 1'b0;
      unlock_level = '0;
      dbg_unlock_mask = '0;
    end
    finish_test("escape", start);

    // Enables from random tokens, levels and single-bit masks
    start = errors;
    restart(5'($urandom_range(19)));
    for (int i = 0; i < 30; i++) begin
      lc_dft_en = ($urandom_range(1) == 1) ? TokenOn : 4'($urandom);
      lc_hw_debug_en = ($urandom_range(1) == 1) ? TokenOn : 4'($urandom);
      unlock_level = random_wide();
      dft_en_mask = one_hot_bit();
      cltap_unlock_mask = one_hot_bit();
      lc_prog_req = ($urandom_range(3) == 0);
      lc_alive_state = ($urandom_range(1) == 1) ? lcc_trans_pkg::SCRAP : lcc_trans_pkg::PROD;
      tick();
    end
    lc_prog_req = 1'b0;
    finish_test("enables", start);

    // Valid low clears everything and valid high restarts the sequence
    start = errors;
    lc_dft_en = TokenOn;
    lc_hw_debug_en = TokenOn;
    restart(5'(8 + $urandom_range(7)));
    expect_security(lcc_trans_pkg::DEV_UNPROVISIONED, 1'b0);
    otp_valid = 1'b0;
    tick();
    expect_security(lcc_trans_pkg::DEV_PRODUCTION, 1'b1);
    otp_valid = 1'b1;
    repeat (3) tick();
    expect_security(lcc_trans_pkg::DEV_UNPROVISIONED, 1'b0);
    finish_test("valid_low", start);

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+dv
verilog/lcc_trans_pkg.sv
verilog/lc_state_capture.sv
verilog/sec_state_fsm.sv
verilog/debug_en_gen.sv
verilog/lcc_st_trans.sv
dv/tb_lcc_st_trans.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the lifecycle translator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module tb_lcc_st_trans -o sim_lcc

./obj_dir/sim_lcc | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
